//--- files.f
rtl/rxfifo_pkg.sv
rtl/rxfifo_bank_ram.sv
rtl/rxfifo_storage.sv
rtl/rxfifo_ptr_ctrl.sv
rtl/rxfifo_flag_gen.sv
rtl/rxfifo_async_top.sv
dv/rxfifo_checker.sv
dv/rxfifo_tb.sv

//--- Bender.yml
package:
  name: rxfifo

sources:
  # Design, package first
  - files:
      - rtl/rxfifo_pkg.sv
      - rtl/rxfifo_bank_ram.sv
      - rtl/rxfifo_storage.sv
      - rtl/rxfifo_ptr_ctrl.sv
      - rtl/rxfifo_flag_gen.sv
      - rtl/rxfifo_async_top.sv

  # Testbench, top module rxfifo_tb
  - target: test
    files:
      - dv/rxfifo_checker.sv
      - dv/rxfifo_tb.sv

//--- dv/rxfifo_tb.sv
//**************************************
// Testbench for the RX clock crossing FIFO
// Config changes only inside a reset, empty_thr is always 0
//**************************************
module rxfifo_tb;

   localparam int      CLK_PERIOD    = 40;
   localparam int      WR_CLK_SKEW   = 13;  // wr_clk lags rd_clk
   localparam int      DRIVE_DLY     = 2;
   localparam int      RESET_CYCLES  = 5;
   localparam int      SETTLE_CYCLES = 10;
   localparam int      EMPTY_READS   = 4;   // Reads pulsed on an empty FIFO
   localparam int      NUM_ROWS      = 8;
   localparam logic [31:0] SEED      = 32'h74e8_1446;

   // One line of the stimulus table
   typedef struct packed {
      rxfifo_pkg::fifo_cfg_t cfg;
      logic [7:0]            n_wr;
      logic [7:0]            n_rd;
      logic                  burst;     // All writes, then all reads
      logic                  rd_empty;  // Extra reads while empty
      logic                  force_wr;  // Keep writing past full
   } row_t;

   logic                    wr_clk;
   logic                    wr_rst_n;
   logic                    wr_en;
   rxfifo_pkg::data_t       wr_data;
   logic                    rd_clk;
   logic                    rd_rst_n;
   logic                    rd_en;
   rxfifo_pkg::fifo_cfg_t   cfg;
   rxfifo_pkg::data_t       rd_data;
   rxfifo_pkg::fifo_flags_t wr_flags;
   rxfifo_pkg::fifo_flags_t rd_flags;
   logic [31:0]             rng_state;

   rxfifo_async_top UUT (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .rd_en    (rd_en),
      .cfg      (cfg),
      .rd_data  (rd_data),
      .wr_flags (wr_flags),
      .rd_flags (rd_flags)
   );

   rxfifo_checker chk (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .cfg      (cfg),
      .wr_flags (wr_flags),
      .rd_flags (rd_flags)
   );

   //**************************************
   // Stimulus table
   //**************************************
   function automatic rxfifo_pkg::fifo_cfg_t make_cfg(input int pempty, input int pfull,
                                                      input logic full_depth);
      rxfifo_pkg::fifo_cfg_t c;
      c.empty_thr  = '0;
      c.pempty_thr = rxfifo_pkg::level_t'(pempty);
      c.pfull_thr  = rxfifo_pkg::level_t'(pfull);
      c.full_thr   = full_depth ? 5'd16 : 5'd8;  // Full at the active depth
      c.full_depth = full_depth;
      return c;
   endfunction

   function automatic row_t make_row(input rxfifo_pkg::fifo_cfg_t c, input int n_wr,
                                     input int n_rd, input logic burst, input logic rd_empty,
                                     input logic force_wr);
      row_t r;
      r.cfg      = c;
      r.n_wr     = 8'(n_wr);
      r.n_rd     = 8'(n_rd);
      r.burst    = burst;
      r.rd_empty = rd_empty;
      r.force_wr = force_wr;
      return r;
   endfunction

   function automatic row_t get_row(input int idx);
      case (idx)
         0: return make_row(make_cfg(4, 12, 1'b1), 40, 40, 1'b0, 1'b0, 1'b0);  // Order
         1: return make_row(make_cfg(4, 12, 1'b1), 19, 16, 1'b1, 1'b0, 1'b1);  // 3 dropped
         2: return make_row(make_cfg(2, 6, 1'b0), 40, 40, 1'b0, 1'b0, 1'b0);   // Half wraps
         3: return make_row(make_cfg(2, 6, 1'b0), 11, 8, 1'b1, 1'b0, 1'b1);    // Half drop
         4: return make_row(make_cfg(2, 6, 1'b0), 10, 10, 1'b0, 1'b1, 1'b0);
         5: return make_row(make_cfg(12, 14, 1'b1), 12, 12, 1'b1, 1'b0, 1'b0);
         6: return make_row(make_cfg(1, 15, 1'b1), 15, 15, 1'b1, 1'b0, 1'b0);
         default: return make_row(make_cfg(1, 15, 1'b1), 20, 20, 1'b0, 1'b1, 1'b0);
      endcase
   endfunction

   // Budget of four cycles per strobe plus slack
   function automatic longint watchdog_limit();
      longint total;
      row_t   r;
      total = 4000;
      for (int i = 0; i < NUM_ROWS; i++) begin
         r = get_row(i);
         total += 4 * (r.n_wr + r.n_rd) * CLK_PERIOD;
      end
      return total;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   //**************************************
   // Clocks and watchdog
   //**************************************
   initial begin
      rd_clk = 1'b0;
      forever #(CLK_PERIOD / 2) rd_clk = ~rd_clk;
   end

   initial begin
      wr_clk = 1'b0;
      #(WR_CLK_SKEW);
      forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
   end

   initial begin
      #(watchdog_limit());
      $display("Watchdog expired at %0t before all rows finished", $time);
      $display("Simulation failed");
      $finish;
   end

   //**************************************
   // Drivers
   //**************************************
   task automatic draw_word(output rxfifo_pkg::data_t word);
      logic [7:0] hi;
      rng_state = xorshift32(rng_state);
      hi        = rng_state[7:0];
      rng_state = xorshift32(rng_state);
      word      = {hi, rng_state};
   endtask

   // Both resets held together while cfg changes
   task automatic apply_reset(input rxfifo_pkg::fifo_cfg_t new_cfg);
      fork
         begin @(posedge wr_clk); #(DRIVE_DLY) wr_rst_n = 1'b0; end
         begin @(posedge rd_clk); #(DRIVE_DLY) rd_rst_n = 1'b0; end
      join
      cfg = new_cfg;
      fork
         begin repeat (RESET_CYCLES) @(posedge wr_clk); #(DRIVE_DLY) wr_rst_n = 1'b1; end
         begin repeat (RESET_CYCLES) @(posedge rd_clk); #(DRIVE_DLY) rd_rst_n = 1'b1; end
      join
      chk.check_reset_flags();
   endtask

   task automatic write_words(input int n, input logic force_wr);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge wr_clk);
         #(DRIVE_DLY);
         if (force_wr || !wr_flags.full) begin  // Back-pressure unless forced
            draw_word(wr_data);
            wr_en = 1'b1;
            @(posedge wr_clk);
            #(DRIVE_DLY) wr_en = 1'b0;
            sent++;
         end
      end
   endtask

   task automatic read_words(input int n);
      int got;
      got = 0;
      while (got < n) begin
         @(posedge rd_clk);
         #(DRIVE_DLY);
         if (!rd_flags.empty) begin
            rd_en = 1'b1;
            @(posedge rd_clk);
            #(DRIVE_DLY) rd_en = 1'b0;
            got++;
         end
      end
   endtask

   // Ignores the empty flag on purpose
   task automatic empty_reads(input int n);
      repeat (n) begin
         @(posedge rd_clk);
         #(DRIVE_DLY) rd_en = 1'b1;
         @(posedge rd_clk);
         #(DRIVE_DLY) rd_en = 1'b0;
      end
   endtask

   task automatic settle;
      fork
         repeat (SETTLE_CYCLES) @(posedge wr_clk);
         repeat (SETTLE_CYCLES) @(posedge rd_clk);
      join
      #(DRIVE_DLY);
   endtask

   task automatic run_row(input int idx);
      row_t r;
      r = get_row(idx);
      if (idx == 0 || r.cfg != cfg) apply_reset(r.cfg);  // Same cfg keeps pointers
      if (r.rd_empty) empty_reads(EMPTY_READS);
      if (r.burst) begin
         write_words(r.n_wr, r.force_wr);
         settle();
         chk.check_flags();  // FIFO holds the burst here
         read_words(r.n_rd);
      end else begin
         fork
            write_words(r.n_wr, r.force_wr);
            read_words(r.n_rd);
         join
      end
      if (r.rd_empty) empty_reads(EMPTY_READS);
      settle();
      chk.check_flags();
      chk.end_row(idx);
   endtask

   //**************************************
   // Main sequence
   //**************************************
   initial begin
      wr_rst_n  = 1'b0;
      rd_rst_n  = 1'b0;
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      wr_data   = '0;
      cfg       = make_cfg(4, 12, 1'b1);
      rng_state = SEED;
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      $display("Summary: %0d rows, %0d checks, %0d errors", NUM_ROWS, chk.checks, chk.errors);
      if (chk.errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- dv/rxfifo_checker.sv
//**************************************
// Reference queue and comparisons for the RX FIFO
// Assumes empty_thr 0 and strobes no closer than every second cycle
//**************************************
module rxfifo_checker (
   input logic                    wr_clk,
   input logic                    wr_rst_n,
   input logic                    wr_en,
   input rxfifo_pkg::data_t       wr_data,
   input logic                    rd_clk,
   input logic                    rd_rst_n,
   input logic                    rd_en,
   input rxfifo_pkg::data_t       rd_data,
   input rxfifo_pkg::fifo_cfg_t   cfg,
   input rxfifo_pkg::fifo_flags_t wr_flags,
   input rxfifo_pkg::fifo_flags_t rd_flags
);

   rxfifo_pkg::data_t ref_q [$];  // Accepted words, oldest first
   rxfifo_pkg::data_t head_word;
   int                errors     = 0;
   int                checks     = 0;
   int                row_errors = 0;  // Cleared at the end of each row
   int                row_checks = 0;

   function automatic int active_depth(input rxfifo_pkg::fifo_cfg_t c);
      return c.full_depth ? 16 : 8;
   endfunction

   // Flag rules applied to the modelled level
   function automatic rxfifo_pkg::fifo_flags_t expected_flags(input int level,
                                                              input rxfifo_pkg::fifo_cfg_t c);
      rxfifo_pkg::fifo_flags_t f;
      f.empty  = (level <= int'(c.empty_thr));
      f.pempty = (level <= int'(c.pempty_thr));
      f.full   = (level >= int'(c.full_thr));
      f.pfull  = (level >= int'(c.pfull_thr));
      return f;
   endfunction

   //**************************************
   // Reporting
   //**************************************
   task automatic report_mismatch(input string name, input logic [rxfifo_pkg::DWIDTH-1:0] exp,
                                  input logic [rxfifo_pkg::DWIDTH-1:0] act);
      $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      errors++;
      row_errors++;
   endtask

   task automatic report_failure(input string what);
      $display("ERROR time=%0t %s", $time, what);
      errors++;
      row_errors++;
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      checks++;
      row_checks++;
      if (act !== exp) report_mismatch(name, exp, act);
   endtask

   task automatic compare_flags(input string dom, input rxfifo_pkg::fifo_flags_t exp,
                                input rxfifo_pkg::fifo_flags_t act);
      compare_bit({dom, ".empty"}, exp.empty, act.empty);
      compare_bit({dom, ".pempty"}, exp.pempty, act.pempty);
      compare_bit({dom, ".full"}, exp.full, act.full);
      compare_bit({dom, ".pfull"}, exp.pfull, act.pfull);
   endtask

   // Called by the testbench once both domains have settled
   task automatic check_flags;
      compare_flags("wr_flags", expected_flags(ref_q.size(), cfg), wr_flags);
      compare_flags("rd_flags", expected_flags(ref_q.size(), cfg), rd_flags);
   endtask

   task automatic check_reset_flags;
      rxfifo_pkg::fifo_flags_t rst_val;
      rst_val.empty  = 1'b1;
      rst_val.pempty = 1'b1;
      rst_val.full   = 1'b0;
      rst_val.pfull  = 1'b0;
      compare_flags("wr_flags", rst_val, wr_flags);
      compare_flags("rd_flags", rst_val, rd_flags);
   endtask

   task automatic end_row(input int idx);
      if (ref_q.size() != 0) begin
         report_failure($sformatf("row %0d ended with %0d words never read", idx, ref_q.size()));
      end
      $display("row %0d done: %0d checks, %0d errors", idx, row_checks, row_errors);
      row_checks = 0;
      row_errors = 0;
   endtask

   //**************************************
   // Watch the ports
   //**************************************
   always @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         ref_q.delete();  // Reset empties the FIFO
      end else if (wr_en && !wr_flags.full && ref_q.size() < active_depth(cfg)) begin
         ref_q.push_back(wr_data);
      end
   end

   // Head word must be on rd_data at the edge that takes it
   always @(posedge rd_clk) begin
      if (rd_rst_n && rd_en && !rd_flags.empty) begin
         if (ref_q.size() == 0) begin
            report_failure("read taken while no word was written");
         end else begin
            head_word = ref_q.pop_front();
            checks++;
            row_checks++;
            if (rd_data !== head_word) report_mismatch("rd_data", head_word, rd_data);
         end
      end
   end

endmodule

//--- rtl/rxfifo_async_top.sv
//**************************************
// RX clock crossing FIFO, 16 or 8 words deep
// Writer should watch wr_flags.full
// Config static outside of reset
//**************************************
module rxfifo_async_top (
   input  logic                    wr_clk,
   input  logic                    wr_rst_n,
   input  logic                    wr_en,
   input  rxfifo_pkg::data_t       wr_data,
   input  logic                    rd_clk,
   input  logic                    rd_rst_n,
   input  logic                    rd_en,
   input  rxfifo_pkg::fifo_cfg_t   cfg,
   output rxfifo_pkg::data_t       rd_data,
   output rxfifo_pkg::fifo_flags_t wr_flags,
   output rxfifo_pkg::fifo_flags_t rd_flags
);

   logic               wr_accept;  // Write taken this edge
   rxfifo_pkg::addr_t  wr_addr;
   rxfifo_pkg::addr_t  rd_addr;
   rxfifo_pkg::level_t wr_level;   // Seen in wr_clk
   rxfifo_pkg::level_t rd_level;   // Seen in rd_clk

   //**************************************
   // Pointer control
   //**************************************
   rxfifo_ptr_ctrl ptr_ctrl (
      .wr_clk    (wr_clk),
      .wr_rst_n  (wr_rst_n),
      .wr_en     (wr_en),
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_en     (rd_en),
      .cfg       (cfg),
      .wr_accept (wr_accept),
      .wr_addr   (wr_addr),
      .rd_addr   (rd_addr),
      .wr_level  (wr_level),
      .rd_level  (rd_level)
   );

   // Banked word storage
   rxfifo_storage storage (
      .wr_clk    (wr_clk),
      .wr_accept (wr_accept),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   //**************************************
   // Status flags, one set per domain
   //**************************************
   rxfifo_flag_gen wr_flag_gen (
      .clk   (wr_clk),
      .rst_n (wr_rst_n),
      .level (wr_level),
      .cfg   (cfg),
      .flags (wr_flags)
   );

   rxfifo_flag_gen rd_flag_gen (
      .clk   (rd_clk),
      .rst_n (rd_rst_n),
      .level (rd_level),
      .cfg   (cfg),
      .flags (rd_flags)
   );

endmodule

//--- rtl/rxfifo_flag_gen.sv
//**************************************
// Threshold flags of one clock domain
// Flags lag the level by one clock
//**************************************
module rxfifo_flag_gen (
   input  logic                    clk,
   input  logic                    rst_n,
   input  rxfifo_pkg::level_t      level,  // Fill level of this domain
   input  rxfifo_pkg::fifo_cfg_t   cfg,
   output rxfifo_pkg::fifo_flags_t flags
);

   rxfifo_pkg::fifo_flags_t flags_nxt;

   //**************************************
   // Compare against thresholds
   //**************************************
   always_comb begin
      flags_nxt.empty  = (level <= cfg.empty_thr);
      flags_nxt.pempty = (level <= cfg.pempty_thr);
      flags_nxt.full   = (level >= cfg.full_thr);
      flags_nxt.pfull  = (level >= cfg.pfull_thr);
   end

   // Reset reads as an empty FIFO
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flags.empty  <= 1'b1;
         flags.pempty <= 1'b1;
         flags.full   <= 1'b0;
         flags.pfull  <= 1'b0;
      end else begin
         flags <= flags_nxt;
      end
   end

endmodule

//--- rtl/rxfifo_ptr_ctrl.sv
//**************************************
// Pointers, Gray crossing and fill levels
// Writes past full and reads past empty are ignored
// Mode must only change while both resets are held
//**************************************
module rxfifo_ptr_ctrl (
   input  logic                  wr_clk,
   input  logic                  wr_rst_n,
   input  logic                  wr_en,
   input  logic                  rd_clk,
   input  logic                  rd_rst_n,
   input  logic                  rd_en,
   input  rxfifo_pkg::fifo_cfg_t cfg,
   output logic                  wr_accept,
   output rxfifo_pkg::addr_t     wr_addr,
   output rxfifo_pkg::addr_t     rd_addr,
   output rxfifo_pkg::level_t    wr_level,
   output rxfifo_pkg::level_t    rd_level
);

   //**************************************
   // Helpers
   //**************************************
   function automatic rxfifo_pkg::ptr_t bin2gray(input rxfifo_pkg::ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic rxfifo_pkg::ptr_t gray2bin(input rxfifo_pkg::ptr_t gray);
      rxfifo_pkg::ptr_t bin;
      bin[rxfifo_pkg::AWIDTH] = gray[rxfifo_pkg::AWIDTH];  // MSB passes through
      for (int i = rxfifo_pkg::AWIDTH - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // Next pointer, wraps at twice the active depth
   function automatic rxfifo_pkg::ptr_t ptr_inc(input rxfifo_pkg::ptr_t ptr,
                                                input logic full_depth);
      rxfifo_pkg::ptr_t nxt;
      nxt = ptr + 1'b1;
      if (!full_depth) begin
         nxt[rxfifo_pkg::AWIDTH] = 1'b0;  // Half depth counts mod 16
      end
      return nxt;
   endfunction

   // Words between head and tail pointer
   function automatic rxfifo_pkg::level_t fill_level(input rxfifo_pkg::ptr_t head,
                                                     input rxfifo_pkg::ptr_t tail,
                                                     input logic full_depth);
      rxfifo_pkg::ptr_t diff;
      diff = head - tail;
      if (!full_depth) begin
         diff[rxfifo_pkg::AWIDTH] = 1'b0;  // Modulo 16 difference
      end
      return rxfifo_pkg::level_t'(diff);
   endfunction

   // Storage address, bank bit forced low in half depth
   function automatic rxfifo_pkg::addr_t to_addr(input rxfifo_pkg::ptr_t ptr,
                                                 input logic full_depth);
      rxfifo_pkg::addr_t addr;
      addr = ptr[rxfifo_pkg::AWIDTH-1:0];
      if (!full_depth) begin
         addr[rxfifo_pkg::AWIDTH-1] = 1'b0;
      end
      return addr;
   endfunction

   rxfifo_pkg::level_t active_depth;  // 16 or 8
   rxfifo_pkg::ptr_t   wr_bin;
   rxfifo_pkg::ptr_t   wr_gray;
   rxfifo_pkg::ptr_t   rd_bin;
   rxfifo_pkg::ptr_t   rd_gray;
   rxfifo_pkg::ptr_t   rd_gray_meta;  // Read pointer, first flop in wr_clk
   rxfifo_pkg::ptr_t   rd_gray_sync;
   rxfifo_pkg::ptr_t   wr_gray_meta;  // Write pointer, first flop in rd_clk
   rxfifo_pkg::ptr_t   wr_gray_sync;
   rxfifo_pkg::ptr_t   wr_bin_nxt;
   rxfifo_pkg::ptr_t   rd_bin_nxt;
   logic               rd_accept;

   assign active_depth = cfg.full_depth ? rxfifo_pkg::level_t'(2 * rxfifo_pkg::BANK_DEPTH)
                                        : rxfifo_pkg::level_t'(rxfifo_pkg::BANK_DEPTH);

   //**************************************
   // Write domain
   //**************************************
   assign wr_level   = fill_level(wr_bin, gray2bin(rd_gray_sync), cfg.full_depth);
   assign wr_accept  = wr_en && (wr_level < active_depth);  // Drop when physically full
   assign wr_bin_nxt = ptr_inc(wr_bin, cfg.full_depth);
   assign wr_addr    = to_addr(wr_bin, cfg.full_depth);

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_accept) begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= bin2gray(wr_bin_nxt);  // Registered so only one bit toggles
      end
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   //**************************************
   // Read domain
   //**************************************
   assign rd_level   = fill_level(gray2bin(wr_gray_sync), rd_bin, cfg.full_depth);
   assign rd_accept  = rd_en && (rd_level != '0);  // No effect when empty
   assign rd_bin_nxt = ptr_inc(rd_bin, cfg.full_depth);
   assign rd_addr    = to_addr(rd_bin, cfg.full_depth);

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_accept) begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= bin2gray(rd_bin_nxt);
      end
   end

   // Write pointer into rd_clk, two to three edges of latency
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end else begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

endmodule

//--- rtl/rxfifo_storage.sv
//**************************************
// Two banks behind one address space
// Bank bit arrives already zeroed in half depth
//**************************************
module rxfifo_storage (
   input  logic              wr_clk,
   input  logic              wr_accept,
   input  rxfifo_pkg::addr_t wr_addr,
   input  rxfifo_pkg::data_t wr_data,
   input  rxfifo_pkg::addr_t rd_addr,
   output rxfifo_pkg::data_t rd_data
);

   logic [rxfifo_pkg::BANK_DEPTH-1:0] wr_sel;  // Decoded entry
   logic                              wr_bank;
   logic                              rd_bank;
   logic                              we_lo;
   logic                              we_hi;
   rxfifo_pkg::data_t                 rd_data_lo;
   rxfifo_pkg::data_t                 rd_data_hi;

   //**************************************
   // Write steering
   //**************************************
   assign wr_bank = wr_addr[rxfifo_pkg::AWIDTH-1];
   assign we_lo   = wr_accept && !wr_bank;  // Upper bank idle in half depth
   assign we_hi   = wr_accept && wr_bank;

   // Binary to one-hot
   always_comb begin
      for (int i = 0; i < rxfifo_pkg::BANK_DEPTH; i++) begin
         wr_sel[i] = (wr_addr[rxfifo_pkg::BANK_AWIDTH-1:0] == i);
      end
   end

   rxfifo_bank_ram bank_lo (
      .wr_clk  (wr_clk),
      .we      (we_lo),
      .wr_sel  (wr_sel),
      .wr_data (wr_data),
      .rd_sel  (rd_addr[rxfifo_pkg::BANK_AWIDTH-1:0]),
      .rd_data (rd_data_lo)
   );

   rxfifo_bank_ram bank_hi (
      .wr_clk  (wr_clk),
      .we      (we_hi),
      .wr_sel  (wr_sel),
      .wr_data (wr_data),
      .rd_sel  (rd_addr[rxfifo_pkg::BANK_AWIDTH-1:0]),
      .rd_data (rd_data_hi)
   );

   // Read side bank mux
   assign rd_bank = rd_addr[rxfifo_pkg::AWIDTH-1];
   assign rd_data = rd_bank ? rd_data_hi : rd_data_lo;

endmodule

//--- rtl/rxfifo_bank_ram.sv
//**************************************
// One bank of 8 words, no reset on contents
// Read is combinational from the index
//**************************************
module rxfifo_bank_ram (
   input  logic                              wr_clk,
   input  logic                              we,       // Bank enable
   input  logic [rxfifo_pkg::BANK_DEPTH-1:0] wr_sel,   // One-hot entry
   input  rxfifo_pkg::data_t                 wr_data,
   input  logic [rxfifo_pkg::BANK_AWIDTH-1:0] rd_sel,  // Binary entry
   output rxfifo_pkg::data_t                 rd_data
);

   //**************************************
   // Storage array
   //**************************************
   rxfifo_pkg::data_t mem [rxfifo_pkg::BANK_DEPTH];

   // Each entry loads on its own select line
   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < rxfifo_pkg::BANK_DEPTH; i++) begin
         if (we && wr_sel[i]) begin
            mem[i] <= wr_data;
         end
      end
   end

   // Head word visible before the read strobe
   assign rd_data = mem[rd_sel];

endmodule

//--- rtl/rxfifo_pkg.sv
//**************************************
// Widths and types shared by the RX FIFO
// Storage is fixed at two banks of 8 words
//**************************************
package rxfifo_pkg;

   //**************************************
   // Sizes
   //**************************************
   localparam int DWIDTH      = 40;  // Adapter word
   localparam int BANK_DEPTH  = 8;   // Entries per bank
   localparam int BANK_AWIDTH = 3;   // Entry index within a bank
   localparam int AWIDTH      = 4;   // Bank bit on top of entry index

   //**************************************
   // Vector types
   //**************************************
   typedef logic [DWIDTH-1:0] data_t;
   typedef logic [AWIDTH:0]   ptr_t;    // One wrap bit above the address
   typedef logic [AWIDTH-1:0] addr_t;   // MSB picks the bank
   typedef logic [AWIDTH:0]   level_t;  // Holds 0 up to 16

   // Static configuration, changed only under reset
   typedef struct packed {
      level_t empty_thr;   // Empty at or below
      level_t pempty_thr;  // Partially empty at or below
      level_t pfull_thr;   // Partially full at or above
      level_t full_thr;    // Full at or above
      logic   full_depth;  // Low selects half depth, lower bank only
   } fifo_cfg_t;

   // Registered status of one clock domain
   typedef struct packed {
      logic empty;
      logic pempty;
      logic full;
      logic pfull;
   } fifo_flags_t;

endpackage
